// ==== wb_pkg.sv ====
`default_nettype none

package wb_pkg;

  // Bus widths in bits
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // One byte select per data byte
  localparam int SEL_WIDTH = DATA_WIDTH / 8;

  // Port counts on each side of the shared bus
  localparam int MASTERS = 2;
  localparam int SLAVES  = 2;

  // Memory map
  // Width gives how many upper address bits define a slave's range
  // Match gives the value those bits must carry, right aligned
  // Slave 0 covers 0x00000000 to 0x7fffffff
  // Slave 1 covers 0xe0000000 to 0xe0ffffff
  // Everything else is unmapped and answered with err
  localparam int SLV_RANGE_WIDTH [SLAVES] = '{1, 8};
  localparam logic [ADDR_WIDTH-1:0] SLV_RANGE_MATCH [SLAVES] = '{
    32'h0000_0000,
    32'h0000_00e0
  };

  // Wishbone B3 request, master to slave
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] dat;
    logic [SEL_WIDTH-1:0]  sel;
    logic                  we;
    logic                  cyc;
    logic                  stb;
    // Cycle type and burst type, routed only
    logic [2:0]            cti;
    logic [1:0]            bte;
  } wb_req_t;

  // Wishbone B3 response, slave to master
  typedef struct packed {
    logic [DATA_WIDTH-1:0] dat;
    logic                  ack;
    logic                  err;
    // Carried through, no slave raises it
    logic                  rty;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== wb_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter import wb_pkg::*; (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wb_req_t [MASTERS-1:0] m_req_i,
  output wb_rsp_t [MASTERS-1:0] m_rsp_o,
  output wb_req_t               bus_req_o,
  input  wb_rsp_t               bus_rsp_i,
  input  wire                   bus_hold_i,
  output logic                  bus_hold_ack_o
);

  logic [MASTERS-1:0] cyc_vec;
  // Registered one-hot grant, zero when the bus is idle
  logic [MASTERS-1:0] grant_q;
  logic [MASTERS-1:0] grant_d;
  // One-hot record of the previous owner, scan starts after it
  logic [MASTERS-1:0] last_q;
  logic               owner_cyc;
  logic               hold_ack_q;

  // Gather cyc of every master
  always_comb begin
    for (int m = 0; m < MASTERS; m++) begin
      cyc_vec[m] = m_req_i[m].cyc;
    end
  end

  // Owner keeps the bus as long as its cyc stays high
  assign owner_cyc = |(grant_q & cyc_vec);

  // Next grant
  always_comb begin : rr_pick
    int   base;
    int   idx;
    logic found;
    base    = 0;
    idx     = 0;
    found   = 1'b0;
    grant_d = grant_q;
    for (int m = 0; m < MASTERS; m++) begin
      if (last_q[m]) base = m;
    end
    if (grant_q != '0) begin
      // Release one cycle after the owner drops cyc
      if (!owner_cyc) grant_d = '0;
    end else if (!bus_hold_i) begin
      // Idle bus, walk the masters round robin
      for (int i = 1; i <= MASTERS; i++) begin
        idx = (base + i) % MASTERS;
        if (!found && cyc_vec[idx]) begin
          grant_d      = '0;
          grant_d[idx] = 1'b1;
          found        = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      grant_q    <= '0;
      // Highest master counts as last owner, so master 0 goes first
      last_q     <= {1'b1, {(MASTERS-1){1'b0}}};
      hold_ack_q <= 1'b0;
    end else begin
      grant_q <= grant_d;
      if (grant_q == '0 && grant_d != '0) last_q <= grant_d;
      // Hold is acknowledged only with no grant outstanding
      hold_ack_q <= bus_hold_i && (grant_q == '0);
    end
  end

  assign bus_hold_ack_o = hold_ack_q;

  // Owner's request onto the shared bus, zeros when idle
  always_comb begin
    bus_req_o = '0;
    for (int m = 0; m < MASTERS; m++) begin
      if (grant_q[m]) bus_req_o = m_req_i[m];
    end
  end

  // Response goes back to the owner only
  always_comb begin
    for (int m = 0; m < MASTERS; m++) begin
      m_rsp_o[m] = grant_q[m] ? bus_rsp_i : '0;
    end
  end

  // Never two owners at once
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant_q));

endmodule

`default_nettype wire

// ==== wb_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_decode import wb_pkg::*; (
  input  wb_req_t              bus_req_i,
  output wb_rsp_t              bus_rsp_o,
  output wb_req_t [SLAVES-1:0] s_req_o,
  input  wb_rsp_t [SLAVES-1:0] s_rsp_i
);

  // One bit per slave whose range matches the address
  logic [SLAVES-1:0] slv_sel;

  // Compare the upper address bits against each range
  always_comb begin
    for (int s = 0; s < SLAVES; s++) begin
      slv_sel[s] = (bus_req_i.adr >> (ADDR_WIDTH - SLV_RANGE_WIDTH[s]))
                   == SLV_RANGE_MATCH[s];
    end
  end

  // Every slave sees the payload
  // cyc and stb reach the matching slave only
  always_comb begin
    for (int s = 0; s < SLAVES; s++) begin
      s_req_o[s]     = bus_req_i;
      s_req_o[s].cyc = bus_req_i.cyc & slv_sel[s];
      s_req_o[s].stb = bus_req_i.stb & slv_sel[s];
    end
  end

  // Return the selected slave's response
  always_comb begin
    bus_rsp_o = '0;
    for (int s = 0; s < SLAVES; s++) begin
      if (slv_sel[s]) bus_rsp_o = s_rsp_i[s];
    end
    // Unmapped address, error in the same cycle
    if (slv_sel == '0 && bus_req_i.cyc && bus_req_i.stb) begin
      bus_rsp_o.err = 1'b1;
    end
  end

  // Ranges in the map must not overlap
  always_comb begin
    a_sel_onehot: assert final ($onehot0(slv_sel));
  end

endmodule

`default_nettype wire

// ==== wb_bus_b3.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_bus_b3 import wb_pkg::*; (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wb_req_t [MASTERS-1:0] m_req_i,
  output wb_rsp_t [MASTERS-1:0] m_rsp_o,
  output wb_req_t [SLAVES-1:0]  s_req_o,
  input  wb_rsp_t [SLAVES-1:0]  s_rsp_i,
  output logic [ADDR_WIDTH-1:0] snoop_adr_o,
  output logic                  snoop_en_o,
  input  wire                   bus_hold_i,
  output logic                  bus_hold_ack_o
);

  // Shared bus between arbiter and decoder
  wb_req_t bus_req;
  wb_rsp_t bus_rsp;

  wb_arbiter u_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .m_req_i        (m_req_i),
    .m_rsp_o        (m_rsp_o),
    .bus_req_o      (bus_req),
    .bus_rsp_i      (bus_rsp),
    .bus_hold_i     (bus_hold_i),
    .bus_hold_ack_o (bus_hold_ack_o)
  );

  wb_decode u_decode (
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .s_req_o   (s_req_o),
    .s_rsp_i   (s_rsp_i)
  );

  // Snoop a write on the cycle it completes
  assign snoop_adr_o = bus_req.adr;
  assign snoop_en_o  = bus_rsp.ack & bus_req.stb & bus_req.we;

  // Slave ack and decoder err must never collide
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bus_rsp.ack && bus_rsp.err));

endmodule

`default_nettype wire

// ==== wb_sram_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_sram_slave import wb_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  wire     clk_i,
  input  wire     rst_n_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [DATA_WIDTH-1:0]        mem [MEM_WORDS];
  logic [DATA_WIDTH-1:0]        rd_q;
  logic                         ack_q;
  logic                         access;
  // Word index right above the byte offset, upper bits alias
  logic [$clog2(MEM_WORDS)-1:0] word_idx;

  assign word_idx = req_i.adr[$clog2(SEL_WIDTH) +: $clog2(MEM_WORDS)];

  // New access, one per stb since ack blocks the repeat
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  // Ack one cycle after the access is seen
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Byte-wise write and registered read
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (req_i.we) begin
        for (int b = 0; b < SEL_WIDTH; b++) begin
          if (req_i.sel[b]) mem[word_idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
        end
      end
      rd_q <= mem[word_idx];
    end
  end

  // Read data lines up with ack
  always_comb begin
    rsp_o     = '0;
    rsp_o.dat = rd_q;
    rsp_o.ack = ack_q;
    // Memory never fails and never asks for retry
    rsp_o.err = 1'b0;
    rsp_o.rty = 1'b0;
  end

endmodule

`default_nettype wire

// ==== wb_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_subsys_top import wb_pkg::*; (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wb_req_t [MASTERS-1:0] m_req_i,
  output wb_rsp_t [MASTERS-1:0] m_rsp_o,
  output logic [ADDR_WIDTH-1:0] snoop_adr_o,
  output logic                  snoop_en_o,
  input  wire                   bus_hold_i,
  output logic                  bus_hold_ack_o
);

  // Slave side of the bus
  wb_req_t [SLAVES-1:0] s_req;
  wb_rsp_t [SLAVES-1:0] s_rsp;

  wb_bus_b3 u_bus (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .m_req_i        (m_req_i),
    .m_rsp_o        (m_rsp_o),
    .s_req_o        (s_req),
    .s_rsp_i        (s_rsp),
    .snoop_adr_o    (snoop_adr_o),
    .snoop_en_o     (snoop_en_o),
    .bus_hold_i     (bus_hold_i),
    .bus_hold_ack_o (bus_hold_ack_o)
  );

  // One SRAM behind each slave port
  for (genvar s = 0; s < SLAVES; s++) begin : g_sram
    wb_sram_slave #(
      .MEM_WORDS (256)
    ) u_sram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (s_req[s]),
      .rsp_o   (s_rsp[s])
    );
  end

endmodule

`default_nettype wire

// ==== tb_wb_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_wb_bus import wb_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT_CYC = 64;
  localparam logic [31:0] SEED = 32'hd288;
  // Outside both slave ranges
  localparam logic [ADDR_WIDTH-1:0] UNMAPPED = 32'h9000_0000;

  logic                  clk;
  logic                  rst_n;
  wb_req_t [MASTERS-1:0] m_req;
  wb_rsp_t [MASTERS-1:0] m_rsp;
  logic [ADDR_WIDTH-1:0] snoop_adr;
  logic                  snoop_en;
  logic                  bus_hold;
  logic                  bus_hold_ack;

  // Reference memory, byte address of a word to its data
  logic [DATA_WIDTH-1:0] model [logic [ADDR_WIDTH-1:0]];
  // Expected outcome of each master's access in flight
  logic [DATA_WIDTH-1:0] exp_dat [MASTERS];
  logic [MASTERS-1:0]    exp_err;
  // High between reset release and the first request
  logic                  idle_chk;

  wb_subsys_top dut_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .m_req_i        (m_req),
    .m_rsp_o        (m_rsp),
    .snoop_adr_o    (snoop_adr),
    .snoop_en_o     (snoop_en),
    .bus_hold_i     (bus_hold),
    .bus_hold_ack_o (bus_hold_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // New bytes replace old ones where sel is set
  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_w,
      input logic [DATA_WIDTH-1:0] new_w, input logic [SEL_WIDTH-1:0] sel);
    logic [DATA_WIDTH-1:0] res;
    res = old_w;
    for (int b = 0; b < SEL_WIDTH; b++) begin
      if (sel[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  // Lower half of the space, or the 16 MB window at 0xe0000000
  function automatic logic is_mapped(input logic [ADDR_WIDTH-1:0] adr);
    return (adr[31] == 1'b0) || (adr[31:24] == 8'he0);
  endfunction

  // Single classic access, held until ack or err
  task automatic bus_access(input int m, input logic we, input logic [ADDR_WIDTH-1:0] adr,
      input logic [DATA_WIDTH-1:0] dat, input logic [SEL_WIDTH-1:0] sel);
    wb_req_t r;
    int      cnt;
    r     = '0;
    r.adr = adr;
    r.dat = dat;
    r.sel = sel;
    r.we  = we;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    cnt   = 0;
    @(posedge clk);
    #1;
    exp_err[m] = !is_mapped(adr);
    if (!we && model.exists(adr)) exp_dat[m] = model[adr];
    m_req[m] = r;
    do begin
      @(negedge clk);
      cnt++;
    end while (!m_rsp[m].ack && !m_rsp[m].err && cnt < TIMEOUT_CYC);
    if (!m_rsp[m].ack && !m_rsp[m].err) begin
      $display("Timeout: master %0d got no ack or err for address 0x%08h", m, adr);
      fail_run();
    end else begin
      if (we && m_rsp[m].ack) begin
        model[adr] = merge_bytes(model.exists(adr) ? model[adr] : '0, dat, sel);
      end
      @(posedge clk);
      #1;
      m_req[m] = '0;
    end
  endtask

  // Full write, partial write, read back, alternating slaves
  task automatic run_master(input int m, input int n);
    logic [ADDR_WIDTH-1:0] adr;
    logic [SEL_WIDTH-1:0]  sel;
    for (int i = 0; i < n; i++) begin
      // Word parity follows the master number so the two never share a word
      adr = {(i % 2 == 0) ? 8'h00 : 8'he0, 14'h0, 8'(($urandom % 128) * 2 + m), 2'b00};
      sel = SEL_WIDTH'($urandom % 15 + 1);
      bus_access(m, 1'b1, adr, $urandom, '1);
      bus_access(m, 1'b1, adr, $urandom, sel);
      bus_access(m, 1'b0, adr, '0, '1);
    end
    // Errored write and read
    bus_access(m, 1'b1, UNMAPPED + 32'(m * 4), $urandom, '1);
    bus_access(m, 1'b0, UNMAPPED, '0, '1);
  endtask

  for (genvar m = 0; m < MASTERS; m++) begin : g_chk
    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
      (m_rsp[m].ack && !m_req[m].we) |-> (m_rsp[m].dat == exp_dat[m]))
      else begin
        $display("Error: m_rsp_o[%0d].dat = 0x%08h, expected 0x%08h", m,
                 $sampled(m_rsp[m].dat), $sampled(exp_dat[m]));
        fail_run();
      end
    // err exactly on unmapped addresses
    a_err_map: assert property (@(posedge clk) disable iff (!rst_n)
      (m_rsp[m].ack || m_rsp[m].err) |-> (m_rsp[m].err == exp_err[m]))
      else begin
        $display("Error: m_rsp_o[%0d].err = 0x%0h, expected 0x%0h", m,
                 $sampled(m_rsp[m].err), $sampled(exp_err[m]));
        fail_run();
      end
    a_rsp_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      (m_rsp[m].ack || m_rsp[m].err) |-> m_req[m].cyc)
      else begin
        $display("Master %0d received a response while its cyc was low", m);
        fail_run();
      end
    // Acked write shows up on the snoop port
    a_snoop_wr: assert property (@(posedge clk) disable iff (!rst_n)
      (m_rsp[m].ack && m_req[m].we) |-> (snoop_en && snoop_adr == m_req[m].adr))
      else begin
        $display("Error: snoop_en_o = 0x%0h snoop_adr_o = 0x%08h, expected 0x1 and 0x%08h",
                 $sampled(snoop_en), $sampled(snoop_adr), $sampled(m_req[m].adr));
        fail_run();
      end
  end

  a_snoop_only: assert property (@(posedge clk) disable iff (!rst_n)
    snoop_en |-> ((m_rsp[0].ack && m_req[0].we) || (m_rsp[1].ack && m_req[1].we)))
    else begin
      $display("Snoop fired without an acknowledged write");
      fail_run();
    end
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_hold_ack |-> !(m_rsp[0].ack || m_rsp[0].err || m_rsp[1].ack || m_rsp[1].err))
    else begin
      $display("A master got a response while the bus hold was acknowledged");
      fail_run();
    end
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    idle_chk |-> (!snoop_en && !bus_hold_ack && m_rsp == '0))
    else begin
      $display("Outputs not quiet after reset");
      fail_run();
    end

  initial begin
    int cnt;
    void'($urandom(SEED));
    cnt      = 0;
    rst_n    = 1'b0;
    bus_hold = 1'b0;
    m_req    = '0;
    exp_err  = '0;
    idle_chk = 1'b0;
    foreach (exp_dat[m]) exp_dat[m] = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    idle_chk = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    idle_chk = 1'b0;
    // Both masters compete for the bus
    fork
      run_master(0, 6);
      run_master(1, 6);
    join
    @(posedge clk);
    #1;
    bus_hold = 1'b1;
    while (!bus_hold_ack && cnt < TIMEOUT_CYC) begin
      @(negedge clk);
      cnt++;
    end
    if (!bus_hold_ack) begin
      $display("Timeout: bus_hold_ack_o never rose");
      fail_run();
    end else begin
      // Master 0 waits behind the hold until it is released
      fork
        bus_access(0, 1'b1, 32'h0000_0040, $urandom, '1);
        begin
          repeat (6) @(posedge clk);
          #1;
          bus_hold = 1'b0;
        end
      join
      bus_access(0, 1'b0, 32'h0000_0040, '0, '1);
      repeat (4) @(posedge clk);
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
wb_pkg.sv
wb_arbiter.sv
wb_decode.sv
wb_bus_b3.sv
wb_sram_slave.sv
wb_subsys_top.sv
tb_wb_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the Wishbone bus testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wb_bus -f sources.f \
  && ./obj_dir/Vtb_wb_bus | tee /dev/stderr | grep -q "Test passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
